// File: design/calc_pkg.sv
package calc_pkg;

    // datapath widths
    localparam int DATA_W = 16;                       // operands and results
    localparam int ALU_W = 2 * DATA_W;                // holds a full signed product
    localparam int MAX_ENTRY = 32767;                 // largest typed magnitude

    // keypad geometry
    localparam int KEYPAD_N = 4;                      // rows and columns
    localparam int COL_W = $clog2(KEYPAD_N);          // column or row index
    localparam int KEY_W = 2 * COL_W;                 // key index, row*4 + col
    localparam int DIGIT_W = 4;                       // one decimal digit

    // debounce timing
    localparam int DEBOUNCE_CYCLES = 10;              // stable cycles before confirm
    localparam int DB_CNT_W = $clog2(DEBOUNCE_CYCLES); // counts 0 .. DEBOUNCE_CYCLES-1

    // operator codes, shared by scanner, controller and ALU
    typedef enum logic [2:0] {
        OP_NONE = 3'b000,
        OP_NEG  = 3'b001,
        OP_ADD  = 3'b010,
        OP_SUB  = 3'b011,
        OP_MUL  = 3'b100
    } op_t;

endpackage

// File: design/key_if.sv
`timescale 1ns/1ps

interface key_if import calc_pkg::*; ();

    logic               read_input;   // confirmed key waiting for the controller
    logic               key_read;     // one-cycle acknowledge
    logic [DIGIT_W-1:0] digit;        // valid for number keys
    op_t                op;           // OP_NONE unless an operator key
    logic               equal;        // '*' key
    logic               clear;        // '#' key

    modport scanner (
        output read_input, digit, op, equal, clear,
        input  key_read
    );

    modport controller (
        input  read_input, digit, op, equal, clear,
        output key_read
    );

endinterface

// File: design/keypad_scanner.sv
`timescale 1ns/1ps

module keypad_scanner import calc_pkg::*; (
    input  logic                clk,
    input  logic                nRST,
    input  logic [KEYPAD_N-1:0] rows,
    output logic [KEYPAD_N-1:0] cols,
    key_if.scanner              key
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SCAN_COL,
        S_WAIT_STABLE,
        S_CONFIRM,
        S_WAIT_RELEASE
    } state_t;

    state_t                state;
    state_t                next_state;
    logic [COL_W-1:0]      col_index;
    logic [DB_CNT_W-1:0]   db_cnt;
    logic                  read_input_q;
    logic [KEY_W-1:0]      key_code;     // latched in confirm
    logic                  row_hit;

    // lowest active row wins, index is row*4 + col
    function automatic logic [KEY_W-1:0] encode_key(input logic [KEYPAD_N-1:0] r,
                                                     input logic [COL_W-1:0]    c);
        logic [COL_W-1:0] row_idx;
        row_idx = '0;
        for (int i = KEYPAD_N - 1; i >= 0; i--) begin
            if (r[i]) begin
                row_idx = COL_W'(i);
            end
        end
        return {row_idx, c};
    endfunction

    assign row_hit = |rows;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= S_IDLE;
            col_index    <= '0;
            db_cnt       <= '0;
            read_input_q <= 1'b0;
        end else begin
            state <= next_state;

            if (state == S_SCAN_COL && !row_hit) begin
                col_index <= col_index + 1'b1;   // wraps after the last column
            end

            if (state == S_WAIT_STABLE && row_hit) begin
                db_cnt <= db_cnt + 1'b1;
            end else begin
                db_cnt <= '0;
            end

            if (state == S_CONFIRM && !read_input_q) begin
                read_input_q <= 1'b1;
            end else if (state == S_WAIT_RELEASE && !row_hit) begin
                read_input_q <= 1'b0;            // key gone, drop the request
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_CONFIRM && !read_input_q) begin
            key_code <= encode_key(rows, col_index);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:         next_state = S_SCAN_COL;
            S_SCAN_COL:     next_state = row_hit ? S_WAIT_STABLE : S_SCAN_COL;
            S_WAIT_STABLE: begin
                if (!row_hit) begin
                    next_state = S_SCAN_COL;     // bounce, resume scanning
                end else if (db_cnt == DB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    next_state = S_CONFIRM;
                end
            end
            S_CONFIRM:      next_state = key.key_read ? S_WAIT_RELEASE : S_CONFIRM;
            S_WAIT_RELEASE: next_state = row_hit ? S_WAIT_RELEASE : S_IDLE;
            default:        next_state = S_IDLE;
        endcase
    end

    // one column driven high at a time
    always_comb begin
        cols            = '0;
        cols[col_index] = 1'b1;
    end

    assign key.read_input = read_input_q;

    always_comb begin
        key.digit = '0;
        key.op    = OP_NONE;
        key.equal = 1'b0;
        key.clear = 1'b0;
        case (key_code)
            4'h0: key.digit = 4'd1;
            4'h1: key.digit = 4'd2;
            4'h2: key.digit = 4'd3;
            4'h3: key.op    = OP_ADD;    // A
            4'h4: key.digit = 4'd4;
            4'h5: key.digit = 4'd5;
            4'h6: key.digit = 4'd6;
            4'h7: key.op    = OP_SUB;    // B
            4'h8: key.digit = 4'd7;
            4'h9: key.digit = 4'd8;
            4'hA: key.digit = 4'd9;
            4'hB: key.op    = OP_MUL;    // C
            4'hC: key.equal = 1'b1;      // *
            4'hD: key.digit = 4'd0;
            4'hE: key.clear = 1'b1;      // #
            4'hF: key.op    = OP_NEG;    // D
            default: ;
        endcase
    end

endmodule

// File: design/calc_controller.sv
`timescale 1ns/1ps

module calc_controller import calc_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    key_if.controller         key,
    output logic [DATA_W-1:0] alu_a,
    output logic [DATA_W-1:0] alu_b,
    output op_t               alu_op,
    input  logic [DATA_W-1:0] alu_result,
    input  logic              alu_ovf,
    output logic [DATA_W-1:0] result,
    output logic              result_valid,
    output logic              overflow
);

    logic                    read_d;        // read_input delayed, for edge detect
    logic                    key_read_q;
    logic                    key_rise;
    logic [DATA_W-1:0]       acc;           // left operand of the chain
    logic [DATA_W-1:0]       entry;         // number being typed
    op_t                     pending;       // operator waiting for its right operand
    logic                    ovf_chain;     // sticky over the current chain
    logic                    new_entry;     // next digit starts a fresh number
    logic [DATA_W-1:0]       result_q;
    logic                    overflow_q;
    logic                    result_valid_q;
    logic                    is_neg;
    logic signed [ALU_W-1:0] base_x;
    logic signed [ALU_W-1:0] next_entry;
    logic                    digit_ok;

    // act once per press, on the rising edge of the request
    assign key_rise = key.read_input & ~read_d;

    // negate works on the entry alone, everything else on acc and entry
    assign is_neg = (key.op == OP_NEG);
    assign alu_a  = is_neg ? entry : acc;
    assign alu_b  = entry;
    assign alu_op = is_neg ? OP_NEG : pending;

    // decimal shift of the entry, checked against the magnitude limit
    assign base_x     = new_entry ? '0 :
                        $signed({{(ALU_W - DATA_W){entry[DATA_W-1]}}, entry});
    assign next_entry = base_x * 10 + $signed({1'b0, key.digit});
    assign digit_ok   = (next_entry <= MAX_ENTRY) && (next_entry >= -MAX_ENTRY);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            read_d         <= 1'b0;
            key_read_q     <= 1'b0;
            acc            <= '0;
            entry          <= '0;
            pending        <= OP_NONE;
            ovf_chain      <= 1'b0;
            new_entry      <= 1'b0;
            result_q       <= '0;
            overflow_q     <= 1'b0;
            result_valid_q <= 1'b0;
        end else begin
            read_d         <= key.read_input;
            key_read_q     <= key_rise;
            // key fields still held while the scanner waits in confirm
            result_valid_q <= key_read_q & key.equal;

            if (key_rise) begin
                if (key.clear) begin
                    acc        <= '0;
                    entry      <= '0;
                    pending    <= OP_NONE;
                    ovf_chain  <= 1'b0;
                    new_entry  <= 1'b0;
                    result_q   <= '0;
                    overflow_q <= 1'b0;
                end else if (key.equal) begin
                    result_q   <= alu_result;
                    overflow_q <= ovf_chain | alu_ovf;
                    entry      <= alu_result;       // result carries into the next chain
                    acc        <= '0;
                    pending    <= OP_NONE;
                    ovf_chain  <= 1'b0;
                    new_entry  <= 1'b1;
                end else if (is_neg) begin
                    entry     <= alu_result;
                    ovf_chain <= ovf_chain | alu_ovf;  // -(-32768) wraps
                end else if (key.op != OP_NONE) begin
                    acc       <= alu_result;        // none code passes the entry
                    pending   <= key.op;
                    entry     <= '0;
                    ovf_chain <= ovf_chain | alu_ovf;
                    new_entry <= 1'b0;
                end else if (digit_ok) begin
                    entry     <= next_entry[DATA_W-1:0];
                    new_entry <= 1'b0;
                end
            end
        end
    end

    assign key.key_read = key_read_q;
    assign result       = result_q;
    assign overflow     = overflow_q;
    assign result_valid = result_valid_q;

endmodule

// File: design/calc_alu.sv
`timescale 1ns/1ps

module calc_alu import calc_pkg::*; (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  op_t               op,
    output logic [DATA_W-1:0] y,
    output logic              ovf
);

    logic signed [ALU_W-1:0] a_x;
    logic signed [ALU_W-1:0] b_x;
    logic signed [ALU_W-1:0] wide;
    logic [ALU_W-DATA_W:0]   upper;     // bits that must all match the sign

    // sign extend both operands to the internal width
    assign a_x = $signed({{(ALU_W - DATA_W){a[DATA_W-1]}}, a});
    assign b_x = $signed({{(ALU_W - DATA_W){b[DATA_W-1]}}, b});

    always_comb begin
        case (op)
            OP_ADD:  wide = a_x + b_x;
            OP_SUB:  wide = a_x - b_x;
            OP_MUL:  wide = a_x * b_x;   // 16x16 product fits in ALU_W
            OP_NEG:  wide = -a_x;
            OP_NONE: wide = b_x;         // pass the right operand
            default: wide = b_x;
        endcase
    end

    // wraps modulo 2^DATA_W
    assign y = wide[DATA_W-1:0];

    // fits the signed range only if the top bits are a pure sign extension
    assign upper = wide[ALU_W-1:DATA_W-1];
    assign ovf   = !((&upper) || (~|upper));

endmodule

// File: design/calc_top.sv
`timescale 1ns/1ps

module calc_top import calc_pkg::*; (
    input  logic                clk,
    input  logic                nRST,
    input  logic [KEYPAD_N-1:0] rows,
    output logic [KEYPAD_N-1:0] cols,
    output logic [DATA_W-1:0]   result,
    output logic                result_valid,
    output logic                overflow
);

    key_if key ();                  // scanner to controller

    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_y;
    op_t               alu_op;
    logic              alu_ovf;

    keypad_scanner scanner0 (
        .clk  (clk),
        .nRST (nRST),
        .rows (rows),
        .cols (cols),
        .key  (key.scanner)
    );

    calc_controller ctrl0 (
        .clk          (clk),
        .nRST         (nRST),
        .key          (key.controller),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_op       (alu_op),
        .alu_result   (alu_y),
        .alu_ovf      (alu_ovf),
        .result       (result),
        .result_valid (result_valid),
        .overflow     (overflow)
    );

    calc_alu alu0 (
        .a   (alu_a),
        .b   (alu_b),
        .op  (alu_op),
        .y   (alu_y),
        .ovf (alu_ovf)
    );

endmodule

// File: testbench/tb_calc.sv
`timescale 1ns/1ps

module tb_calc import calc_pkg::*; ();

    localparam int    CLK_HALF       = 4;        // 8 ns period
    localparam int    RESET_CYCLES   = 4;
    localparam int    HOLD_CYCLES    = 40;       // well past scan plus debounce
    localparam int    SHORT_CYCLES   = 6;        // below DEBOUNCE_CYCLES
    localparam int    LONG_CYCLES    = 200;
    localparam int    IDLE_CYCLES    = 20;
    localparam int    RESULT_TIMEOUT = 2000;
    localparam int    STIM_DEPTH     = 256;
    localparam int    RAND_SEED      = 36696;
    localparam string STIM_FILE      = "testbench/calc_stim.txt";

    // command field in bits 31:28 of a stimulus word
    localparam logic [3:0] CMD_PRESS  = 4'h1;
    localparam logic [3:0] CMD_SHORT  = 4'h2;
    localparam logic [3:0] CMD_LONG   = 4'h3;
    localparam logic [3:0] CMD_CHECK  = 4'h4;
    localparam logic [3:0] CMD_RANDOM = 4'h5;
    localparam logic [3:0] CMD_END    = 4'hF;

    // key indices as row*4 + col
    localparam logic [3:0] KEY_ADD   = 4'h3;
    localparam logic [3:0] KEY_SUB   = 4'h7;
    localparam logic [3:0] KEY_MUL   = 4'hB;
    localparam logic [3:0] KEY_EQUAL = 4'hC;
    localparam logic [3:0] KEY_CLEAR = 4'hE;

    logic                clk;
    logic                nRST;
    logic [KEYPAD_N-1:0] rows;
    logic [KEYPAD_N-1:0] cols;
    logic [DATA_W-1:0]   result;
    logic                result_valid;
    logic                overflow;

    logic                press_active;
    logic [3:0]          press_key;
    logic [31:0]         stim_mem [STIM_DEPTH];
    int                  valid_count = 0;     // result_valid pulses seen
    int                  checked_count = 0;   // pulses already used by a check
    int                  checks_done = 0;
    logic [DATA_W-1:0]   seen_result;
    logic                seen_ovf;

    calc_top dut0 (
        .clk          (clk),
        .nRST         (nRST),
        .rows         (rows),
        .cols         (cols),
        .result       (result),
        .result_valid (result_valid),
        .overflow     (overflow)
    );

    always #CLK_HALF clk = ~clk;

    // matrix model where the pressed key links its column to its row
    always_comb begin
        rows = '0;
        if (press_active && cols[press_key[1:0]]) begin
            rows[press_key[3:2]] = 1'b1;
        end
    end

    // sampled mid-cycle away from the rising edge
    always @(negedge clk) begin
        if (nRST && result_valid) begin
            valid_count = valid_count + 1;
            seen_result = result;
            seen_ovf    = overflow;
        end
    end

    // one column driven at a time
    always @(negedge clk) begin
        check_equal($countones(cols), 1, "driven column count");
    end

    task automatic next_edge();
        @(posedge clk);
        #1;                                      // inputs move 1 ns after the edge
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_edge();
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic press(input logic [3:0] k, input int hold);
        press_key    = k;
        press_active = 1'b1;
        wait_cycles(hold);
        press_active = 1'b0;
        wait_cycles(IDLE_CYCLES);
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        while (valid_count == checked_count && waited < RESULT_TIMEOUT) begin
            next_edge();
            waited++;
        end
        if (valid_count == checked_count) begin
            $display("Timeout: result_valid did not pulse within %0d cycles", RESULT_TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1, "no result");
        end
    endtask

    task automatic check_result(input logic [DATA_W-1:0] exp_y, input logic exp_ovf);
        wait_result();
        check_equal(valid_count - checked_count, 1, "result_valid pulse count");
        check_equal(seen_result, exp_y, "result");
        check_equal(seen_ovf, exp_ovf, "overflow");
        check_equal(result, seen_result, "result held after the pulse");
        checked_count = valid_count;
        checks_done++;
    endtask

    // keypad layout 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D
    function automatic logic [3:0] digit_key(input int d);
        case (d)
            1:       return 4'h0;
            2:       return 4'h1;
            3:       return 4'h2;
            4:       return 4'h4;
            5:       return 4'h5;
            6:       return 4'h6;
            7:       return 4'h8;
            8:       return 4'h9;
            9:       return 4'hA;
            default: return 4'hD;                // zero
        endcase
    endfunction

    task automatic type_number(input int value);
        int digits[$];
        int v;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digits[i]) begin
            press(digit_key(digits[i]), HOLD_CYCLES);
        end
    endtask

    task automatic random_rounds(input int count);
        int         a;
        int         b;
        int         limit;
        int         wide;
        logic [3:0] op_key;
        for (int n = 0; n < count; n++) begin
            limit = ($urandom % 2 == 0) ? 255 : MAX_ENTRY;   // small or full range
            a     = $urandom % (limit + 1);
            b     = $urandom % (limit + 1);
            case ($urandom % 3)
                0: begin
                    op_key = KEY_ADD;
                    wide   = a + b;
                end
                1: begin
                    op_key = KEY_SUB;
                    wide   = a - b;
                end
                default: begin
                    op_key = KEY_MUL;
                    wide   = a * b;                          // fits in 32 bits
                end
            endcase
            press(KEY_CLEAR, HOLD_CYCLES);
            type_number(a);
            press(op_key, HOLD_CYCLES);
            type_number(b);
            press(KEY_EQUAL, HOLD_CYCLES);
            check_result(wide[DATA_W-1:0], (wide > MAX_ENTRY) || (wide < -MAX_ENTRY - 1));
        end
    endtask

    initial begin
        int          pc;
        logic [31:0] word;
        clk          = 1'b0;
        nRST         = 1'b0;
        press_active = 1'b0;
        press_key    = '0;
        void'($urandom(RAND_SEED));
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = {CMD_END, 28'h0};
        end
        $readmemh(STIM_FILE, stim_mem);

        wait_cycles(RESET_CYCLES);
        check_equal(cols, 4'b0001, "cols in reset");         // scan starts at column 0
        check_equal(result_valid, 1'b0, "result_valid in reset");
        check_equal(result, '0, "result in reset");
        check_equal(overflow, 1'b0, "overflow in reset");
        nRST = 1'b1;
        wait_cycles(2);

        pc = 0;
        while (pc < STIM_DEPTH && stim_mem[pc][31:28] != CMD_END) begin
            word = stim_mem[pc];
            case (word[31:28])
                CMD_PRESS:  press(word[3:0], HOLD_CYCLES);
                CMD_SHORT:  press(word[3:0], SHORT_CYCLES);
                CMD_LONG:   press(word[3:0], LONG_CYCLES);
                CMD_CHECK:  check_result(word[15:0], word[16]);
                CMD_RANDOM: random_rounds(int'(word[7:0]));
                default: begin
                    $display("Unknown command 0x%0h in stimulus word %0d", word[31:28], pc);
                    $display("Simulation FAILED");
                    $fatal(1, "bad stimulus");
                end
            endcase
            pc++;
        end

        if (checks_done == 0) begin
            $display("No result was checked, the stimulus file is empty or missing");
            $display("Simulation FAILED");
            $fatal(1, "nothing checked");
        end else begin
            $display("%0d results checked", checks_done);
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: calc.f
design/calc_pkg.sv
design/key_if.sv
design/keypad_scanner.sv
design/calc_controller.sv
design/calc_alu.sv
design/calc_top.sv
testbench/tb_calc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the calculator testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_calc -f calc.f -o Vtb_calc

# the simulator output goes to the log, the verdict comes from the log
./obj_dir/Vtb_calc | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
else
    echo "run_sim.sh: pass line not found in sim.log"
    exit 1
fi

// File: testbench/calc_stim.txt
// one hex word per command, cmd in bits 31:28: 1 press, 2 short press, 3 long press,
// 4 check (bit 16 overflow, bits 15:0 result), 5 random rounds (bits 7:0), f end
// press words carry the key index row*4+col in bits 3:0
// digit entry
10000000 10000001 10000002 1000000c 4000007b // 1 2 3 = gives 123
// chain evaluated left to right
10000008 10000003 10000005 1000000b 10000002 1000000c 40000024 // 7 + 5 x 3 = gives 36
10000001 10000007 1000000a 1000000c 4000fff9 // 2 - 9 = gives -7
// negate, then reuse of the result
10000004 1000000f 1000000c 4000fffc // 4 neg = gives -4
10000003 10000006 1000000c 40000002 // + 6 = gives 2
// overflow on add and on multiply
10000002 1000000d 1000000d 1000000d 1000000d 10000003 // 30000 +
10000002 1000000d 1000000d 1000000d 1000000d 1000000c 4001ea60 // 30000 = gives -5536
10000002 1000000d 1000000d 1000000b 10000002 1000000d 1000000d // 300 x 300
1000000c 40015f90 // = gives 24464 wrapped
// clear and the entry limit
1000000e 10000009 1000000c 40000008 // # 8 = gives 8
10000002 10000001 10000008 10000006 10000008 1000000a // 3 2 7 6 7 9
1000000c 40007fff // = gives 32767, last digit dropped
// debounce and release
1000000e 20000005 1000000c 40000000 // # then a too short 5, = gives 0
30000008 1000000c 40000007 // 7 held long counts once
// random operands
50000008 // eight rounds
f0000000
